//--- filelist.f
logic/rv_isa_pkg.sv
logic/rv_fetch_pkg.sv
logic/rv_fetch_pc.sv
logic/rv_fetch_buf.sv
logic/rv_fetch_predict.sv
logic/rv_fetch.sv
verification/rv_fetch_checker.sv
verification/rv_fetch_tb.sv

//--- logic/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch
    import rv_fetch_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset_n,
    input  logic    i_pc_select,
    input  addr_t   i_pc_target,
    input  word_t   i_instruction,
    input  logic    i_ack,
    input  logic    i_ready,
    output addr_t   o_addr,
    output logic    o_cyc,
    output logic    o_valid,
    output addr_t   o_pc,
    output word_t   o_instr,
    output logic    o_pred_taken
);

    logic   ack_accept;
    logic   flush;
    logic   room;
    logic   accept;
    logic   pred_taken;
    logic   pred_redirect;
    addr_t  start_pc;
    addr_t  pred_target;

    assign accept = o_valid & i_ready;

    rv_fetch_pc u_pc
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_pc_select        (i_pc_select),
        .i_pc_target        (i_pc_target),
        .i_pred_redirect    (pred_redirect),
        .i_pred_target      (pred_target),
        .i_room             (room),
        .i_ack              (i_ack),
        .o_cyc              (o_cyc),
        .o_addr             (o_addr),
        .o_ack_accept       (ack_accept),
        .o_flush            (flush),
        .o_start_pc         (start_pc)
    );

    rv_fetch_buf u_buf
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_ack_accept       (ack_accept),
        .i_data             (i_instruction),
        .i_flush            (flush),
        .i_start_pc         (start_pc),
        .i_pred_taken       (pred_taken),
        .i_ready            (i_ready),
        .o_room             (room),
        .o_valid            (o_valid),
        .o_pc               (o_pc),
        .o_instr            (o_instr),
        .o_pred_taken       (o_pred_taken)
    );

    // Looks at the instruction on offer, redirects only once decode takes it
    rv_fetch_predict u_predict
    (
        .i_instr            (o_instr),
        .i_pc               (o_pc),
        .i_accept           (accept),
        .o_pred_taken       (pred_taken),
        .o_pred_redirect    (pred_redirect),
        .o_pred_target      (pred_target)
    );

endmodule

//--- logic/rv_fetch_buf.sv
`timescale 1ns/1ps

module rv_fetch_buf
    import rv_isa_pkg::*, rv_fetch_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset_n,
    input  logic    i_ack_accept,
    input  word_t   i_data,
    input  logic    i_flush,
    input  addr_t   i_start_pc,
    input  logic    i_pred_taken,
    input  logic    i_ready,
    output logic    o_room,
    output logic    o_valid,
    output addr_t   o_pc,
    output word_t   o_instr,
    output logic    o_pred_taken
);

    half_t      queue [BUF_HALFWORDS];
    half_t      queue_next [BUF_HALFWORDS];
    buf_count_t count;
    buf_count_t count_popped;
    buf_count_t count_next;
    buf_count_t pop_n;
    addr_t      head_pc;
    logic       skip_lo;
    logic       head_is32;
    logic       accept;

    assign head_is32 = (queue[0][1:0] == LEN32_MARK);

    // A 32-bit head needs its second parcel, possibly from the next word
    assign o_valid = head_is32 ? (count >= buf_count_t'(2)) : (count != '0);
    assign accept  = o_valid & i_ready;
    assign pop_n   = !accept  ? buf_count_t'(0) :
                     head_is32 ? buf_count_t'(2) :
                                 buf_count_t'(1);

    // Two parcels free before a request goes out
    assign o_room = (count <= buf_count_t'(BUF_HALFWORDS - 2));

    assign o_pc         = head_pc;
    assign o_instr      = head_is32 ? {queue[1], queue[0]} : {16'h0000, queue[0]};
    assign o_pred_taken = i_pred_taken;

    always_comb
    begin
        count_popped = count - pop_n;
        count_next   = count_popped;

        // Rotate out consumed parcels
        // Slots past the count are don't-care
        for (int i = 0; i < BUF_HALFWORDS; i++)
        begin
            queue_next[i] = queue[(i + int'(pop_n)) % BUF_HALFWORDS];
        end

        if (i_ack_accept)
        begin
            for (int i = 0; i < BUF_HALFWORDS; i++)
            begin
                if (buf_count_t'(i) == count_popped)
                    queue_next[i] = skip_lo ? i_data[31:16] : i_data[15:0];
                else if (!skip_lo && (buf_count_t'(i) == count_popped + buf_count_t'(1)))
                    queue_next[i] = i_data[31:16];
            end
            count_next = count_popped + (skip_lo ? buf_count_t'(1) : buf_count_t'(2));
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            count   <= '0;
            skip_lo <= RESET_ADDR[1];
            head_pc <= RESET_ADDR;
        end
        else if (i_flush)
        begin
            count   <= '0;
            skip_lo <= i_start_pc[1];    // Target in the upper half of its word
            head_pc <= i_start_pc;
        end
        else
        begin
            count <= count_next;
            if (i_ack_accept)
                skip_lo <= 1'b0;
            if (accept)
                head_pc <= head_pc + (head_is32 ? 32'd4 : 32'd2);
        end
    end

    always_ff @(posedge i_clk)
    begin
        queue <= queue_next;
    end

endmodule

//--- logic/rv_fetch_pc.sv
`timescale 1ns/1ps

module rv_fetch_pc
    import rv_fetch_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset_n,
    input  logic    i_pc_select,
    input  addr_t   i_pc_target,
    input  logic    i_pred_redirect,
    input  addr_t   i_pred_target,
    input  logic    i_room,
    input  logic    i_ack,
    output logic    o_cyc,
    output addr_t   o_addr,
    output logic    o_ack_accept,
    output logic    o_flush,
    output addr_t   o_start_pc
);

    pc_state_t  state;
    pc_state_t  state_next;
    addr_t      fetch_pc;
    addr_t      pc_next;
    addr_t      req_addr;
    addr_t      redirect_pc;
    logic       redirect;
    logic       issue;

    assign redirect    = i_pc_select | i_pred_redirect;
    assign redirect_pc = i_pc_select ? i_pc_target : i_pred_target;    // Execute wins

    assign o_flush      = redirect;
    assign o_start_pc   = redirect_pc;
    assign o_ack_accept = (state == WAIT) & i_ack & ~redirect;

    // Bit 1 of fetch_pc is kept for the buffer, the bus never sees it
    assign pc_next = redirect     ? redirect_pc :
                     o_ack_accept ? fetch_pc + 32'd4 :
                                    fetch_pc;

    always_comb
    begin
        state_next = state;
        issue      = 1'b0;
        case (state)
            IDLE:
            begin
                issue = redirect | i_room;    // Flush leaves the queue empty
            end
            WAIT:
            begin
                if (i_ack)
                begin
                    issue      = redirect;
                    state_next = IDLE;
                end
                else if (redirect)
                    state_next = DROP;
            end
            DROP:
            begin
                issue = i_ack;    // Queue was flushed, room is certain
            end
            default:
                state_next = IDLE;
        endcase
        if (issue)
            state_next = WAIT;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state    <= IDLE;
            fetch_pc <= RESET_ADDR;
        end
        else
        begin
            state    <= state_next;
            fetch_pc <= pc_next;
        end
    end

    // Address register for the request in flight
    always_ff @(posedge i_clk)
    begin
        if (issue)
            req_addr <= {pc_next[31:2], 2'b00};
    end

    assign o_cyc  = (state != IDLE);
    assign o_addr = req_addr;

endmodule

//--- logic/rv_fetch_pkg.sv
package rv_fetch_pkg;

    typedef logic [31:0] word_t;    // Bus data and full instruction
    typedef logic [31:0] addr_t;    // Byte address
    typedef logic [15:0] half_t;    // One parcel

    // First fetch address out of reset
    localparam addr_t RESET_ADDR = 32'h0000_0100;

    // Prefetch queue depth in parcels
    localparam int BUF_HALFWORDS = 4;

    typedef logic [2:0] buf_count_t;    // 0 to BUF_HALFWORDS

    typedef enum logic [1:0]
    {
        IDLE = 2'd0,    // No request on the bus
        WAIT = 2'd1,    // Request held until ack
        DROP = 2'd2     // Stale request, ack is discarded
    } pc_state_t;

endpackage

//--- logic/rv_fetch_predict.sv
`timescale 1ns/1ps

module rv_fetch_predict
    import rv_isa_pkg::*, rv_fetch_pkg::*;
(
    input  word_t   i_instr,
    input  addr_t   i_pc,
    input  logic    i_accept,
    output logic    o_pred_taken,
    output logic    o_pred_redirect,
    output addr_t   o_pred_target
);

    opcode_t    opcode;
    addr_t      j_offs;
    addr_t      b_offs;
    logic       is32;
    logic       is_jal;
    logic       is_back_branch;

    assign opcode = i_instr[6:0];
    assign is32   = (i_instr[1:0] == LEN32_MARK);

    // J-type and B-type immediates, sign extended
    assign j_offs = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                     i_instr[30:21], 1'b0};
    assign b_offs = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                     i_instr[11:8], 1'b0};

    assign is_jal         = is32 && (opcode == OPC_JAL);
    assign is_back_branch = is32 && (opcode == OPC_BRANCH) && i_instr[31];    // Loops

    assign o_pred_taken    = is_jal | is_back_branch;
    assign o_pred_target   = i_pc + (is_jal ? j_offs : b_offs);
    assign o_pred_redirect = o_pred_taken & i_accept;

endmodule

//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcode field, bits [6:0] of a 32-bit encoding
    typedef logic [6:0] opcode_t;

    // Opcode values include the two length bits
    localparam opcode_t OPC_JAL    = 7'b110_1111;
    localparam opcode_t OPC_BRANCH = 7'b110_0011;

    // Low pattern of a 32-bit instruction
    // Any other pattern marks a compressed one
    localparam logic [1:0] LEN32_MARK = 2'b11;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the fetch-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module rv_fetch_tb -o rv_fetch_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/rv_fetch_sim > sim.log 2>&1 || echo "simulation exited with an error"
cat sim.log

grep -q "test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "test passed" sim.log || { echo "FAIL: no result in sim.log"; exit 1; }
echo "PASS"

//--- verification/rv_fetch_checker.sv
`timescale 1ns/1ps

module rv_fetch_checker
    import rv_fetch_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset_n,
    input  logic    i_pc_select,
    input  logic    i_ack,
    input  logic    i_ready,
    input  logic    o_cyc,
    input  addr_t   o_addr,
    input  logic    o_valid,
    input  addr_t   o_pc,
    input  word_t   o_instr,
    input  logic    o_pred_taken
);

    // Request held until its ack
    assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_cyc && !i_ack |=> o_cyc && $stable(o_addr))
    else $error("bus request changed before ack");

    assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_cyc |-> (o_addr[1:0] == 2'b00))
    else $error("bus address not word aligned");

    // Decode side holds under stall unless execute redirects
    assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_valid && !i_ready && !i_pc_select |=>
            o_valid && $stable(o_pc) && $stable(o_instr) && $stable(o_pred_taken))
    else $error("decode outputs moved during stall");

    assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_pc_select |=> !o_valid)
    else $error("instruction offered right after redirect");

endmodule

bind rv_fetch rv_fetch_checker rv_fetch_checker_inst
(
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_pc_select    (i_pc_select),
    .i_ack          (i_ack),
    .i_ready        (i_ready),
    .o_cyc          (o_cyc),
    .o_addr         (o_addr),
    .o_valid        (o_valid),
    .o_pc           (o_pc),
    .o_instr        (o_instr),
    .o_pred_taken   (o_pred_taken)
);

//--- verification/rv_fetch_tb.sv
`timescale 1ns/1ps

module rv_fetch_tb
    import rv_isa_pkg::*, rv_fetch_pkg::*;
();

    localparam int MEM_HALFS  = 1024;    // 2 KiB with wrapping addresses
    localparam int NUM_ROWS   = 8;
    localparam int PLANT_NONE = 0;
    localparam int PLANT_JAL  = 1;
    localparam int PLANT_BACK = 2;
    localparam int PLANT_FWD  = 3;
    localparam int MODE_RESET = 0;    // Continue from reset without redirect
    localparam int MODE_BUSY  = 1;    // Redirect with a request in flight
    localparam int MODE_IDLE  = 2;    // Redirect with the bus idle

    // Offsets of the planted transfers
    localparam logic [20:0] JAL_OFFS  = -21'sd256;
    localparam logic [12:0] BACK_OFFS = -13'sd16;
    localparam logic [12:0] FWD_OFFS  = 13'h0040;

    typedef struct
    {
        addr_t  target;
        int     count;
        bit     throttle;
        int     plant;
        int     mode;
    } row_t;

    logic   i_clk;
    logic   i_reset_n;
    logic   i_pc_select;
    addr_t  i_pc_target;
    word_t  i_instruction;
    logic   i_ack;
    logic   i_ready;
    addr_t  o_addr;
    logic   o_cyc;
    logic   o_valid;
    addr_t  o_pc;
    word_t  o_instr;
    logic   o_pred_taken;

    half_t          mem [MEM_HALFS];
    row_t           rows [NUM_ROWS];
    logic [31:0]    stim_seed;
    logic [31:0]    bus_seed;
    logic           bus_pend;
    int             bus_cnt;
    int             cycles;
    int             cycle_limit;
    int             err_count;
    int             check_count;
    addr_t          pc_exp;

    rv_fetch rv_fetch_inst
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_pc_select    (i_pc_select),
        .i_pc_target    (i_pc_target),
        .i_instruction  (i_instruction),
        .i_ack          (i_ack),
        .i_ready        (i_ready),
        .o_addr         (o_addr),
        .o_cyc          (o_cyc),
        .o_valid        (o_valid),
        .o_pc           (o_pc),
        .o_instr        (o_instr),
        .o_pred_taken   (o_pred_taken)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic half_t parcel_at(input addr_t a);
        return mem[a[10:1]];
    endfunction

    // Reference walker from the ISA length and immediate rules
    function automatic word_t instr_at(input addr_t pc);
        half_t lo;
        lo = parcel_at(pc);
        if (lo[1:0] == 2'b11)
            return {parcel_at(pc + 32'd2), lo};
        return {16'h0000, lo};
    endfunction

    function automatic logic predicted(input word_t ins);
        if (ins[1:0] != 2'b11)
            return 1'b0;
        return (ins[6:0] == OPC_JAL) || ((ins[6:0] == OPC_BRANCH) && ins[31]);
    endfunction

    function automatic addr_t next_pc(input addr_t pc, input word_t ins);
        logic [20:0] j_imm;
        logic [12:0] b_imm;
        j_imm = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        b_imm = {ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        if (predicted(ins))
            return (ins[6:0] == OPC_JAL) ? pc + {{11{j_imm[20]}}, j_imm}
                                         : pc + {{19{b_imm[12]}}, b_imm};
        return pc + ((ins[1:0] == 2'b11) ? 32'd4 : 32'd2);
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        check_count++;
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, got, exp);
            err_count++;
        end
    endtask

    task automatic build_program();
        int h;
        half_t lo;
        h = 0;
        while (h < MEM_HALFS)
        begin
            stim_seed = lcg_step(stim_seed);
            lo = stim_seed[31:16];
            if (stim_seed[24] && (h + 1 < MEM_HALFS))
            begin
                lo[1:0] = 2'b11;
                if ((lo[6:0] == OPC_JAL) || (lo[6:0] == OPC_BRANCH))
                    lo[6:0] = 7'b011_0011;    // Plain ALU op instead
                mem[h] = lo;
                stim_seed = lcg_step(stim_seed);
                mem[h + 1] = stim_seed[31:16];
                h += 2;
            end
            else
            begin
                if (lo[1:0] == 2'b11)
                    lo[1:0] = 2'b01;
                mem[h] = lo;
                h++;
            end
        end
    endtask

    task automatic store_word(input addr_t at, input word_t enc);
        mem[at[10:1]]        = enc[15:0];
        mem[at[10:1] + 10'd1] = enc[31:16];
    endtask

    function automatic word_t jal_enc(input logic [20:0] o);
        return {o[20], o[10:1], o[11], o[19:12], 5'd1, OPC_JAL};
    endfunction

    function automatic word_t beq_enc(input logic [12:0] o);
        return {o[12], o[10:5], 5'd2, 5'd1, 3'b000, o[4:1], o[11], OPC_BRANCH};
    endfunction

    // Planted transfer sits at the row's target
    task automatic plant_transfer(input int r);
        case (rows[r].plant)
            PLANT_JAL:
                store_word(rows[r].target, jal_enc(JAL_OFFS));
            PLANT_BACK:
                store_word(rows[r].target, beq_enc(BACK_OFFS));
            PLANT_FWD:
                store_word(rows[r].target, beq_enc(FWD_OFFS));
            default:
                ;
        endcase
    endtask

    task automatic run_row(input int r);
        int     got;
        int     lows;
        int     errs_before;
        word_t  exp_instr;
        errs_before = err_count;
        if (rows[r].mode != MODE_RESET)
        begin
            if (rows[r].mode == MODE_IDLE)
            begin
                // Two idle samples in a row mean the queue is full
                lows = 0;
                while (lows < 2)
                begin
                    @(posedge i_clk);
                    lows = o_cyc ? 0 : lows + 1;
                end
            end
            else
                @(posedge i_clk);
            i_pc_select <= 1'b1;
            i_pc_target <= rows[r].target;
            @(posedge i_clk);
            if (rows[r].mode == MODE_BUSY)
                @(posedge i_clk);    // Second redirect lands on a fresh request
            i_pc_select <= 1'b0;
            pc_exp = rows[r].target;
        end
        i_ready <= 1'b1;
        got = 0;
        while (got < rows[r].count)
        begin
            @(posedge i_clk);
            if (o_valid && i_ready)
            begin
                exp_instr = instr_at(pc_exp);
                check(o_pc, pc_exp, "decode pc");
                check(o_instr, exp_instr, "decode instruction");
                check(o_pred_taken, predicted(exp_instr), "prediction flag");
                pc_exp = next_pc(pc_exp, exp_instr);
                got++;
            end
            stim_seed = lcg_step(stim_seed);
            if (got == rows[r].count)
                i_ready <= 1'b0;
            else
                i_ready <= rows[r].throttle ? stim_seed[20] : 1'b1;
        end
        $display("row %0d target %h: %0d instructions, %0d errors", r, rows[r].target,
                 got, err_count - errs_before);
    endtask

    initial
    begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // Bus slave acking 1 to 3 cycles after cyc rises
    always @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            i_ack    <= 1'b0;
            bus_pend <= 1'b0;
            bus_cnt  <= 0;
        end
        else if (i_ack)
        begin
            i_ack    <= 1'b0;
            bus_pend <= 1'b0;
        end
        else if (o_cyc)
        begin
            if (!bus_pend)
            begin
                bus_seed = lcg_step(bus_seed);
                if (bus_seed[25:24] == 2'd0)
                begin
                    i_ack         <= 1'b1;
                    i_instruction <= {mem[{o_addr[10:2], 1'b1}], mem[{o_addr[10:2], 1'b0}]};
                end
                else
                begin
                    bus_pend <= 1'b1;
                    bus_cnt  <= (bus_seed[25:24] == 2'd3) ? 1 : 0;
                end
            end
            else if (bus_cnt == 0)
            begin
                i_ack         <= 1'b1;
                i_instruction <= {mem[{o_addr[10:2], 1'b1}], mem[{o_addr[10:2], 1'b0}]};
            end
            else
                bus_cnt <= bus_cnt - 1;
        end
    end

    always @(posedge i_clk)
    begin
        cycles <= cycles + 1;
        if ((cycle_limit > 0) && (cycles >= cycle_limit))
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    initial
    begin
        int total;
        i_reset_n     = 1'b0;
        i_pc_select   = 1'b0;
        i_pc_target   = '0;
        i_instruction = '0;
        i_ack         = 1'b0;
        i_ready       = 1'b0;
        stim_seed     = 32'd20098;
        bus_seed      = 32'd20098 ^ 32'h5a5a_0000;
        bus_pend      = 1'b0;
        bus_cnt       = 0;
        cycles        = 0;
        cycle_limit   = 0;
        err_count     = 0;
        check_count   = 0;

        rows[0] = '{32'h0000_0100, 20, 1'b0, PLANT_NONE, MODE_RESET};
        rows[1] = '{32'h0000_0202, 25, 1'b0, PLANT_NONE, MODE_BUSY};
        rows[2] = '{32'h0000_0306, 25, 1'b1, PLANT_NONE, MODE_IDLE};
        rows[3] = '{32'h0000_0400, 6,  1'b0, PLANT_JAL,  MODE_BUSY};
        rows[4] = '{32'h0000_0480, 8,  1'b0, PLANT_BACK, MODE_IDLE};
        rows[5] = '{32'h0000_0500, 6,  1'b0, PLANT_FWD,  MODE_BUSY};
        rows[6] = '{32'h0000_0582, 30, 1'b1, PLANT_JAL,  MODE_IDLE};
        rows[7] = '{32'h0000_0640, 40, 1'b1, PLANT_NONE, MODE_BUSY};

        build_program();
        foreach (rows[r])
            plant_transfer(r);

        total = 0;
        foreach (rows[r])
            total += rows[r].count;
        cycle_limit = total * 16 + 500;

        for (int i = 0; i < 16; i++)
        begin
            @(posedge i_clk);
            if (i > 0)
            begin
                check(o_cyc, 1'b0, "o_cyc during reset");
                check(o_valid, 1'b0, "o_valid during reset");
            end
        end
        i_reset_n <= 1'b1;
        @(posedge i_clk);
        @(posedge i_clk);
        check(o_cyc, 1'b1, "first request after reset");
        check(o_addr, RESET_ADDR, "first request address");
        pc_exp = RESET_ADDR;

        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);

        $display("%0d tests, %0d checks, %0d errors", NUM_ROWS, check_count, err_count);
        if (err_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
